// File: source/dm_pkg.sv
`default_nettype none

package dm_pkg;

  // --------------------------------------------------
  // DMI transport
  // --------------------------------------------------
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_ERR     = 2'h2,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dtm_op_e     op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dtm_resp_e   resp;
  } dmi_resp_t;

  // --------------------------------------------------
  // debug module registers
  // --------------------------------------------------
  typedef enum logic [2:0] {
    CMDERR_NONE       = 3'd0,
    CMDERR_BUSY       = 3'd1,
    CMDERR_NOTSUP     = 3'd2,
    CMDERR_EXCEPTION  = 3'd3,
    CMDERR_HALTRESUME = 3'd4,
    CMDERR_BUS        = 3'd5,
    CMDERR_OTHER      = 3'd7
  } cmderr_e;

  typedef enum logic [7:0] {
    DATA0        = 8'h04,
    DMCONTROL    = 8'h10,
    DMSTATUS     = 8'h11,
    ABSTRACTCS   = 8'h16,
    COMMAND      = 8'h17,
    ABSTRACTAUTO = 8'h18,
    PROGBUF0     = 8'h20,
    HALTSUM0     = 8'h40
  } dm_csr_e;

  localparam logic [3:0] DmVersion = 4'd2; // spec 0.13

  // abstractcs / abstractauto field positions
  localparam int CmderrLsb      = 8;
  localparam int BusyBit        = 12;
  localparam int ProgbufSizeLsb = 24;
  localparam int AutoProgbufLsb = 16;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;       // not supported
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;           // not supported
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq; // not supported
    logic       clrresethaltreq; // not supported
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic        dmcontrol_we;
    logic [31:0] wdata;
  } hart_wr_t;

  typedef struct packed {
    logic        data_acc;    // read or write, not busy
    logic        progbuf_acc;
    logic        data_we;
    logic        progbuf_we;
    logic        command_we;
    logic        auto_we;
    logic [3:0]  idx;
    logic [31:0] wdata;
  } abs_wr_t;

endpackage

`default_nettype wire

// File: source/dm_resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dm_resp_fifo import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      push_i,
  input  dmi_resp_t data_i,
  input  logic      pop_i,
  output dmi_resp_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  dmi_resp_t  mem_q [2];
  logic       rd_ptr_q, wr_ptr_q;
  logic [1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (flush_i) begin // DTM reset drops pending responses
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push_i) wr_ptr_q <= ~wr_ptr_q;
      if (pop_i)  rd_ptr_q <= ~rd_ptr_q;
      cnt_q <= cnt_q + 2'(push_i) - 2'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == 2'd2);
  assign empty_o = (cnt_q == 2'd0);

  // producer and consumer sit outside, they must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o) && !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: source/dm_hart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dm_hart_ctrl import dm_pkg::*; #(
  parameter int NrHarts = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hart_wr_t           wr_i,
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] unavailable_i,
  input  logic [NrHarts-1:0] resumeack_i,
  output dmcontrol_t         dmcontrol_o,
  output logic [31:0]        dmstatus_o,
  output logic [31:0]        haltsum0_o,
  output logic [19:0]        hartsel_o,
  output logic [NrHarts-1:0] haltreq_o,
  output logic [NrHarts-1:0] resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o
);

  localparam int SelW = (NrHarts > 1) ? $clog2(NrHarts) : 1;

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  logic [NrHarts-1:0] havereset_d, havereset_q;
  logic [SelW-1:0]    sel;
  logic               sel_exists;
  logic               halted_sel, unavail_sel, resumeack_sel, havereset_sel;

  assign hartsel_o  = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign sel        = hartsel_o[SelW-1:0];
  assign sel_exists = (hartsel_o < 20'(NrHarts));

  // status of the selected hart, zero when it does not exist
  assign halted_sel    = sel_exists & halted_i[sel];
  assign unavail_sel   = sel_exists & unavailable_i[sel];
  assign resumeack_sel = sel_exists & resumeack_i[sel];
  assign havereset_sel = sel_exists & havereset_q[sel];

  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    havereset_d       = havereset_q;
    clear_resumeack_o = 1'b0;
    if (wr_i.dmcontrol_we) begin
      dmcontrol_d = dmcontrol_t'(wr_i.wdata);
      if (dmcontrol_d.ackhavereset && sel_exists) havereset_d[sel] = 1'b0;
      // unsupported and write-only bits
      dmcontrol_d.hartreset       = 1'b0;
      dmcontrol_d.ackhavereset    = 1'b0;
      dmcontrol_d.zero1           = 1'b0;
      dmcontrol_d.hasel           = 1'b0;
      dmcontrol_d.zero0           = 2'b0;
      dmcontrol_d.setresethaltreq = 1'b0;
      dmcontrol_d.clrresethaltreq = 1'b0;
      // fresh resume request, drop the stale ack
      clear_resumeack_o = dmcontrol_q.dmactive & ~dmcontrol_q.resumereq
                          & dmcontrol_d.resumereq;
    end
    if (dmcontrol_q.resumereq && resumeack_sel) dmcontrol_d.resumereq = 1'b0;
    if (dmcontrol_q.ndmreset) havereset_d = '1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else if (!dmcontrol_q.dmactive) begin // only dmactive is writable
      dmcontrol_q <= dmcontrol_t'({31'b0, dmcontrol_d.dmactive});
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  always_comb begin
    dmstatus_o        = '0;
    dmstatus_o[19:18] = {2{havereset_sel}};
    dmstatus_o[17:16] = {2{resumeack_sel}};
    dmstatus_o[15:14] = {2{~sel_exists}};                           // nonexistent
    dmstatus_o[13:12] = {2{unavail_sel}};
    dmstatus_o[11:10] = {2{sel_exists & ~halted_sel & ~unavail_sel}}; // running
    dmstatus_o[9:8]   = {2{halted_sel & ~unavail_sel}};
    dmstatus_o[7]     = 1'b1;                                        // authenticated
    dmstatus_o[3:0]   = DmVersion;
  end

  // one group of 32 harts at most
  assign haltsum0_o = (hartsel_o[19:5] == '0) ? 32'(halted_i) : '0;

  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel]   = dmcontrol_q.haltreq;
      resumereq_o[sel] = dmcontrol_q.resumereq;
    end
  end

  assign dmcontrol_o = dmcontrol_q;
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;

  // haltsum1..3 are not implemented
  assert property (@(posedge clk_i) NrHarts >= 1 && NrHarts <= 32);

endmodule

`default_nettype wire

// File: source/dm_abstract_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dm_abstract_regs import dm_pkg::*; #(
  parameter int DataCount   = 2,
  parameter int ProgBufSize = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           dmactive_i,
  input  abs_wr_t                        wr_i,
  input  logic                           data_valid_i,
  input  logic [DataCount-1:0][31:0]     data_i,
  output logic [31:0]                    rd_data_o,
  output logic [31:0]                    rd_progbuf_o,
  output logic [31:0]                    abstractauto_o,
  output logic                           cmd_valid_o,
  output logic [31:0]                    cmd_o,
  output logic [DataCount-1:0][31:0]     data_o,
  output logic [ProgBufSize-1:0][31:0]   progbuf_o
);

  // autoexecprogbuf in [31:16], autoexecdata in [11:0]
  localparam logic [31:0] AutoMask = (((32'h1 << ProgBufSize) - 32'h1) << AutoProgbufLsb)
                                   | ((32'h1 << DataCount) - 32'h1);

  logic [DataCount-1:0][31:0]   data_q;
  logic [ProgBufSize-1:0][31:0] progbuf_q;
  logic [31:0]                  command_q;
  logic [31:0]                  auto_q;
  logic                         cmd_valid_d, cmd_valid_q;

  // re-run the last command on an access with its autoexec bit set
  assign cmd_valid_d = wr_i.command_we
                     | (wr_i.data_acc & auto_q[wr_i.idx])
                     | (wr_i.progbuf_acc & auto_q[AutoProgbufLsb + int'(wr_i.idx)]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q      <= '0;
      progbuf_q   <= '0;
      command_q   <= '0;
      auto_q      <= '0;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      data_q      <= '0;
      progbuf_q   <= '0;
      command_q   <= '0;
      auto_q      <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_valid_d;
      if (wr_i.data_we)    data_q[wr_i.idx]    <= wr_i.wdata;
      if (wr_i.progbuf_we) progbuf_q[wr_i.idx] <= wr_i.wdata;
      if (wr_i.command_we) command_q           <= wr_i.wdata;
      if (wr_i.auto_we)    auto_q              <= wr_i.wdata & AutoMask;
      if (data_valid_i)    data_q              <= data_i; // hart writeback wins
    end
  end

  // guarded, the index covers the widest range
  assign rd_data_o    = (int'(wr_i.idx) < DataCount)   ? data_q[wr_i.idx]    : '0;
  assign rd_progbuf_o = (int'(wr_i.idx) < ProgBufSize) ? progbuf_q[wr_i.idx] : '0;

  assign abstractauto_o = auto_q;
  assign cmd_valid_o    = cmd_valid_q;
  assign cmd_o          = command_q;
  assign data_o         = data_q;
  assign progbuf_o      = progbuf_q;

  // the hart side raises cmdbusy before a second command can land
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

`default_nettype wire

// File: source/dm_csr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dm_csr_ctrl import dm_pkg::*; #(
  parameter int DataCount   = 2,
  parameter int ProgBufSize = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  dmi_req_t    req_i,
  input  logic        req_ready_i,
  input  logic        cmdbusy_i,
  input  logic        cmderror_valid_i,
  input  cmderr_e     cmderror_i,
  input  logic        dmactive_i,
  input  dmcontrol_t  dmcontrol_i,
  input  logic [31:0] dmstatus_i,
  input  logic [31:0] haltsum0_i,
  input  logic [31:0] rd_data_i,
  input  logic [31:0] rd_progbuf_i,
  input  logic [31:0] abstractauto_i,
  output hart_wr_t    hart_wr_o,
  output abs_wr_t     abs_wr_o,
  output logic        resp_push_o,
  output dmi_resp_t   resp_o
);

  dm_csr_e     csr;
  logic [7:0]  addr;
  logic        accept, is_rd, is_wr, in_data, in_prog, busy_hit, wr_ok;
  logic [31:0] abstractcs, rdata;
  cmderr_e     cmderr_d, cmderr_q;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign addr    = {1'b0, req_i.addr};
  assign csr     = dm_csr_e'(addr);
  assign accept  = req_valid_i & req_ready_i;
  assign is_rd   = accept & (req_i.op == DTM_READ);
  assign is_wr   = accept & (req_i.op == DTM_WRITE);
  assign in_data = (addr >= DATA0) && (int'(addr) < int'(DATA0) + DataCount);
  assign in_prog = (addr >= PROGBUF0) && (int'(addr) < int'(PROGBUF0) + ProgBufSize);
  assign wr_ok   = is_wr & ~cmdbusy_i;

  // abstract side is locked while a command runs
  assign busy_hit = cmdbusy_i & (((is_rd | is_wr) & (in_data | in_prog))
                  | (is_wr & (csr inside {ABSTRACTCS, COMMAND, ABSTRACTAUTO})));

  assign hart_wr_o.dmcontrol_we = is_wr & (csr == DMCONTROL);
  assign hart_wr_o.wdata        = req_i.data;

  assign abs_wr_o.data_acc    = (is_rd | is_wr) & in_data & ~cmdbusy_i;
  assign abs_wr_o.progbuf_acc = (is_rd | is_wr) & in_prog & ~cmdbusy_i;
  assign abs_wr_o.data_we     = wr_ok & in_data;
  assign abs_wr_o.progbuf_we  = wr_ok & in_prog;
  assign abs_wr_o.command_we  = wr_ok & (csr == COMMAND);
  assign abs_wr_o.auto_we     = wr_ok & (csr == ABSTRACTAUTO);
  assign abs_wr_o.idx         = in_prog ? 4'(addr - PROGBUF0) : 4'(addr - DATA0);
  assign abs_wr_o.wdata       = req_i.data;

  // --------------------------------------------------
  // cmderr and abstractcs
  // --------------------------------------------------
  always_comb begin
    cmderr_d = cmderr_q;
    if (wr_ok && csr == ABSTRACTCS) begin // write 1 to clear
      cmderr_d = cmderr_e'(cmderr_q & ~req_i.data[CmderrLsb +: 3]);
    end
    if (busy_hit && cmderr_q == CMDERR_NONE) cmderr_d = CMDERR_BUSY;
    if (cmderror_valid_i) cmderr_d = cmderror_i; // hart error has priority
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)          cmderr_q <= CMDERR_NONE;
    else if (!dmactive_i) cmderr_q <= CMDERR_NONE;
    else                  cmderr_q <= cmderr_d;
  end

  always_comb begin
    abstractcs                        = '0;
    abstractcs[ProgbufSizeLsb +: 5]   = 5'(ProgBufSize);
    abstractcs[BusyBit]               = cmdbusy_i;
    abstractcs[CmderrLsb +: 3]        = cmderr_q;
    abstractcs[3:0]                   = 4'(DataCount);
  end

  // --------------------------------------------------
  // read mux and response
  // --------------------------------------------------
  always_comb begin
    rdata = '0; // unmapped and command
    if (in_data)      rdata = rd_data_i;
    else if (in_prog) rdata = rd_progbuf_i;
    else begin
      case (csr)
        DMCONTROL:    rdata = dmcontrol_i;
        DMSTATUS:     rdata = dmstatus_i;
        ABSTRACTCS:   rdata = abstractcs;
        ABSTRACTAUTO: rdata = abstractauto_i;
        HALTSUM0:     rdata = haltsum0_i;
        default:      rdata = '0;
      endcase
    end
  end

  assign resp_push_o = accept;
  assign resp_o.data = is_rd ? rdata : '0;
  assign resp_o.resp = busy_hit ? DTM_BUSY : DTM_SUCCESS;

endmodule

`default_nettype wire

// File: source/dm_csrs_top.sv
`timescale 1ns/1ps
`default_nettype none

module dm_csrs_top import dm_pkg::*; #(
  parameter int NrHarts     = 2,
  parameter int DataCount   = 2,
  parameter int ProgBufSize = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         dmi_rst_ni,       // DTM reset, flushes responses
  input  logic                         dmi_req_valid_i,
  output logic                         dmi_req_ready_o,
  input  dmi_req_t                     dmi_req_i,
  output logic                         dmi_resp_valid_o,
  input  logic                         dmi_resp_ready_i,
  output dmi_resp_t                    dmi_resp_o,
  output logic                         ndmreset_o,
  output logic                         dmactive_o,
  input  logic [NrHarts-1:0]           halted_i,
  input  logic [NrHarts-1:0]           unavailable_i,
  input  logic [NrHarts-1:0]           resumeack_i,
  output logic [19:0]                  hartsel_o,
  output logic [NrHarts-1:0]           haltreq_o,
  output logic [NrHarts-1:0]           resumereq_o,
  output logic                         clear_resumeack_o,
  output logic                         cmd_valid_o,
  output logic [31:0]                  cmd_o,
  input  logic                         cmderror_valid_i,
  input  cmderr_e                      cmderror_i,
  input  logic                         cmdbusy_i,
  output logic [ProgBufSize-1:0][31:0] progbuf_o,
  output logic [DataCount-1:0][31:0]   data_o,
  input  logic [DataCount-1:0][31:0]   data_i,
  input  logic                         data_valid_i
);

  hart_wr_t    hart_wr;
  abs_wr_t     abs_wr;
  dmcontrol_t  dmcontrol;
  dmi_resp_t   resp;
  logic [31:0] dmstatus, haltsum0, rd_data, rd_progbuf, abstractauto;
  logic        resp_push, resp_full, resp_empty;

  assign dmi_req_ready_o  = ~resp_full;
  assign dmi_resp_valid_o = ~resp_empty;

  dm_csr_ctrl #(.DataCount(DataCount), .ProgBufSize(ProgBufSize)) i_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i      (dmi_req_valid_i),
    .req_i            (dmi_req_i),
    .req_ready_i      (dmi_req_ready_o),
    .cmdbusy_i, .cmderror_valid_i, .cmderror_i,
    .dmactive_i       (dmactive_o),
    .dmcontrol_i      (dmcontrol),
    .dmstatus_i       (dmstatus),
    .haltsum0_i       (haltsum0),
    .rd_data_i        (rd_data),
    .rd_progbuf_i     (rd_progbuf),
    .abstractauto_i   (abstractauto),
    .hart_wr_o        (hart_wr),
    .abs_wr_o         (abs_wr),
    .resp_push_o      (resp_push),
    .resp_o           (resp)
  );

  dm_hart_ctrl #(.NrHarts(NrHarts)) i_hart_ctrl (
    .clk_i, .rst_ni,
    .wr_i             (hart_wr),
    .halted_i, .unavailable_i, .resumeack_i,
    .dmcontrol_o      (dmcontrol),
    .dmstatus_o       (dmstatus),
    .haltsum0_o       (haltsum0),
    .hartsel_o, .haltreq_o, .resumereq_o, .clear_resumeack_o,
    .ndmreset_o, .dmactive_o
  );

  dm_abstract_regs #(.DataCount(DataCount), .ProgBufSize(ProgBufSize)) i_abs_regs (
    .clk_i, .rst_ni,
    .dmactive_i       (dmactive_o),
    .wr_i             (abs_wr),
    .data_valid_i, .data_i,
    .rd_data_o        (rd_data),
    .rd_progbuf_o     (rd_progbuf),
    .abstractauto_o   (abstractauto),
    .cmd_valid_o, .cmd_o, .data_o, .progbuf_o
  );

  dm_resp_fifo i_resp_fifo (
    .clk_i, .rst_ni,
    .flush_i          (~dmi_rst_ni),
    .push_i           (resp_push),
    .data_i           (resp),
    .pop_i            (dmi_resp_ready_i & ~resp_empty),
    .data_o           (dmi_resp_o),
    .full_o           (resp_full),
    .empty_o          (resp_empty)
  );

endmodule

`default_nettype wire

// File: sim/tb_dm_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dm_csrs import dm_pkg::*; ();

  localparam int NrHarts     = 2;
  localparam int DataCount   = 2;
  localparam int ProgBufSize = 8;
  localparam int MaxCycles   = 2000; // generous margin over the six directed tests

  logic                         clk_i;
  logic                         rst_ni;
  logic                         dmi_rst_ni;
  logic                         dmi_req_valid_i;
  logic                         dmi_req_ready_o;
  dmi_req_t                     dmi_req_i;
  logic                         dmi_resp_valid_o;
  logic                         dmi_resp_ready_i;
  dmi_resp_t                    dmi_resp_o;
  logic                         ndmreset_o;
  logic                         dmactive_o;
  logic [NrHarts-1:0]           halted_i;
  logic [NrHarts-1:0]           unavailable_i;
  logic [NrHarts-1:0]           resumeack_i;
  logic [19:0]                  hartsel_o;
  logic [NrHarts-1:0]           haltreq_o;
  logic [NrHarts-1:0]           resumereq_o;
  logic                         clear_resumeack_o;
  logic                         cmd_valid_o;
  logic [31:0]                  cmd_o;
  logic                         cmderror_valid_i;
  cmderr_e                      cmderror_i;
  logic                         cmdbusy_i;
  logic [ProgBufSize-1:0][31:0] progbuf_o;
  logic [DataCount-1:0][31:0]   data_o;
  logic [DataCount-1:0][31:0]   data_i;
  logic                         data_valid_i;

  integer      seed = 98807;
  int          cycles = 0;
  logic        cmd_seen;  // cmd_valid_o one cycle after the last accepted request
  logic        clr_seen;  // clear_resumeack_o in the accept cycle
  logic [31:0] data_ref [DataCount];
  logic [31:0] prog_ref [ProgBufSize];
  logic [31:0] cmd_ref;

  dm_csrs_top #(
    .NrHarts     (NrHarts),
    .DataCount   (DataCount),
    .ProgBufSize (ProgBufSize)
  ) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MaxCycles) begin
      $display("Run stopped, no end of the tests within %0d cycles", MaxCycles);
      $display("Errors found");
      $fatal(1);
    end
  end

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // dmcontrol layout from the debug spec 0.13
  function automatic logic [31:0] ctrl_word(input logic haltreq, input logic resumereq,
                                            input logic [9:0] hartsel);
    logic [31:0] w;
    w        = 32'h0;
    w[31]    = haltreq;
    w[30]    = resumereq;
    w[25:16] = hartsel;
    w[0]     = 1'b1; // dmactive
    return w;
  endfunction

  // dmstatus of one selected hart with equal any/all pairs
  function automatic logic [31:0] status_word(input logic havereset, input logic resumeack,
                                              input logic nonexist, input logic unavail,
                                              input logic running, input logic halted);
    logic [31:0] w;
    w        = 32'h0;
    w[19:18] = {2{havereset}};
    w[17:16] = {2{resumeack}};
    w[15:14] = {2{nonexist}};
    w[13:12] = {2{unavail}};
    w[11:10] = {2{running}};
    w[9:8]   = {2{halted}};
    w[7]     = 1'b1;  // authenticated
    w[3:0]   = 4'd2;  // version 0.13
    return w;
  endfunction

  // --------------------------------------------------
  // DMI driver starting and ending just after a rising edge
  // --------------------------------------------------
  task automatic dmi_access(input dtm_op_e op, input logic [6:0] addr, input logic [31:0] wdata,
                            input dtm_resp_e exp_resp, output logic [31:0] rdata);
    dmi_req_valid_i <= 1'b1;
    dmi_req_i       <= '{addr: addr, data: wdata, op: op};
    @(posedge clk_i);
    while (!dmi_req_ready_o) @(posedge clk_i);
    clr_seen         = clear_resumeack_o;
    dmi_req_valid_i <= 1'b0;
    dmi_req_i       <= '{addr: 7'h0, data: 32'h0, op: DTM_NOP};
    @(posedge clk_i);
    cmd_seen = cmd_valid_o;
    assert (dmi_resp_valid_o)
      else report_failure("no response one cycle after the accepted request");
    expect_eq("dmi_resp_o.resp", 32'(dmi_resp_o.resp), 32'(exp_resp));
    rdata = dmi_resp_o.data;
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata,
                           input dtm_resp_e exp_resp);
    logic [31:0] unused;
    dmi_access(DTM_WRITE, addr, wdata, exp_resp, unused);
  endtask

  task automatic dmi_read(input logic [6:0] addr, output logic [31:0] rdata);
    dmi_access(DTM_READ, addr, 32'h0, DTM_SUCCESS, rdata);
  endtask

  task automatic check_read(input logic [6:0] addr, input string name, input logic [31:0] exp);
    logic [31:0] got;
    dmi_read(addr, got);
    expect_eq(name, got, exp);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic reset_test();
    expect_eq("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'h0);
    expect_eq("cmd_valid_o", 32'(cmd_valid_o), 32'h0);
    expect_eq("haltreq_o", 32'(haltreq_o), 32'h0);
    expect_eq("resumereq_o", 32'(resumereq_o), 32'h0);
    expect_eq("ndmreset_o", 32'(ndmreset_o), 32'h0);
    expect_eq("dmactive_o", 32'(dmactive_o), 32'h0);
    expect_eq("clear_resumeack_o", 32'(clear_resumeack_o), 32'h0);
    check_read(7'(DMCONTROL), "dmcontrol", 32'h0);
    check_read(7'(DMSTATUS), "dmstatus", status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    dmi_write(7'(DMCONTROL), 32'h1, DTM_SUCCESS);
    expect_eq("dmactive_o", 32'(dmactive_o), 32'h1);
    // unsupported bits plus ackhavereset for hart 0
    dmi_write(7'(DMCONTROL), 32'h3C00_003D, DTM_SUCCESS);
    check_read(7'(DMCONTROL), "dmcontrol", 32'h1);
    check_read(7'(DMSTATUS), "dmstatus", status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
  endtask

  task automatic hart_test();
    dmi_write(7'(DMCONTROL), ctrl_word(1'b1, 1'b0, 10'd1), DTM_SUCCESS);
    expect_eq("haltreq_o", 32'(haltreq_o), 32'h2);
    expect_eq("hartsel_o", 32'(hartsel_o), 32'h1);
    halted_i <= 2'b10;
    check_read(7'(DMSTATUS), "dmstatus", status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    check_read(7'(HALTSUM0), "haltsum0", 32'h2);

    dmi_write(7'(DMCONTROL), ctrl_word(1'b0, 1'b1, 10'd1), DTM_SUCCESS);
    expect_eq("clear_resumeack_o", 32'(clr_seen), 32'h1);
    expect_eq("resumereq_o", 32'(resumereq_o), 32'h2);
    resumeack_i <= 2'b10;
    @(posedge clk_i);
    check_read(7'(DMCONTROL), "dmcontrol", ctrl_word(1'b0, 1'b0, 10'd1));
    expect_eq("resumereq_o", 32'(resumereq_o), 32'h0);
    resumeack_i <= 2'b00;

    // hart 5 does not exist
    dmi_write(7'(DMCONTROL), ctrl_word(1'b1, 1'b1, 10'd5), DTM_SUCCESS);
    expect_eq("haltreq_o", 32'(haltreq_o), 32'h0);
    expect_eq("resumereq_o", 32'(resumereq_o), 32'h0);
    check_read(7'(DMSTATUS), "dmstatus", status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    dmi_write(7'(DMCONTROL), ctrl_word(1'b0, 1'b0, 10'd0), DTM_SUCCESS);
  endtask

  task automatic data_test();
    for (int i = 0; i < DataCount; i++) begin
      data_ref[i] = $random(seed);
      dmi_write(7'(DATA0) + 7'(i), data_ref[i], DTM_SUCCESS);
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      prog_ref[i] = $random(seed);
      dmi_write(7'(PROGBUF0) + 7'(i), prog_ref[i], DTM_SUCCESS);
    end
    for (int i = 0; i < DataCount; i++) begin
      check_read(7'(DATA0) + 7'(i), $sformatf("data%0d", i), data_ref[i]);
      expect_eq($sformatf("data_o[%0d]", i), data_o[i], data_ref[i]);
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      check_read(7'(PROGBUF0) + 7'(i), $sformatf("progbuf%0d", i), prog_ref[i]);
      expect_eq($sformatf("progbuf_o[%0d]", i), progbuf_o[i], prog_ref[i]);
    end
    // hart writeback
    for (int i = 0; i < DataCount; i++) begin
      data_ref[i] = $random(seed);
      data_i[i]  <= data_ref[i];
    end
    data_valid_i <= 1'b1;
    @(posedge clk_i);
    data_valid_i <= 1'b0;
    for (int i = 0; i < DataCount; i++) begin
      check_read(7'(DATA0) + 7'(i), $sformatf("data%0d", i), data_ref[i]);
      expect_eq($sformatf("data_o[%0d]", i), data_o[i], data_ref[i]);
    end
    check_read(7'h30, "unmapped", 32'h0);
  endtask

  task automatic command_test();
    cmd_ref = $random(seed);
    dmi_write(7'(COMMAND), cmd_ref, DTM_SUCCESS);
    expect_eq("cmd_valid_o", 32'(cmd_seen), 32'h1);
    expect_eq("cmd_o", cmd_o, cmd_ref);
    @(posedge clk_i);
    expect_eq("cmd_valid_o", 32'(cmd_valid_o), 32'h0); // single cycle only
    check_read(7'(COMMAND), "command", 32'h0);

    cmdbusy_i <= 1'b1;
    dmi_write(7'(COMMAND), ~cmd_ref, DTM_BUSY);
    expect_eq("cmd_valid_o", 32'(cmd_seen), 32'h0);
    expect_eq("cmd_o", cmd_o, cmd_ref);
    check_read(7'(ABSTRACTCS), "abstractcs", 32'h0800_1102); // busy with cmderr 1
    cmdbusy_i <= 1'b0;
    dmi_write(7'(ABSTRACTCS), 32'h0000_0700, DTM_SUCCESS);
    check_read(7'(ABSTRACTCS), "abstractcs", 32'h0800_0002);

    cmderror_valid_i <= 1'b1;
    cmderror_i       <= CMDERR_EXCEPTION;
    @(posedge clk_i);
    cmderror_valid_i <= 1'b0;
    cmderror_i       <= CMDERR_NONE;
    check_read(7'(ABSTRACTCS), "abstractcs", 32'h0800_0302);
    dmi_write(7'(ABSTRACTCS), 32'h0000_0700, DTM_SUCCESS);
    check_read(7'(ABSTRACTCS), "abstractcs", 32'h0800_0002);
  endtask

  task automatic autoexec_test();
    // only 8 progbuf and 2 data bits exist
    dmi_write(7'(ABSTRACTAUTO), 32'hFFFF_FFFF, DTM_SUCCESS);
    check_read(7'(ABSTRACTAUTO), "abstractauto", 32'h00FF_0003);
    dmi_write(7'(ABSTRACTAUTO), 32'h0000_0001, DTM_SUCCESS);
    check_read(7'(ABSTRACTAUTO), "abstractauto", 32'h0000_0001);
    data_ref[0] = $random(seed);
    dmi_write(7'(DATA0), data_ref[0], DTM_SUCCESS);
    expect_eq("cmd_valid_o", 32'(cmd_seen), 32'h1);
    expect_eq("cmd_o", cmd_o, cmd_ref);
    data_ref[1] = $random(seed);
    dmi_write(7'(DATA0) + 7'd1, data_ref[1], DTM_SUCCESS);
    expect_eq("cmd_valid_o", 32'(cmd_seen), 32'h0);
    dmi_write(7'(ABSTRACTAUTO), 32'h0, DTM_SUCCESS);
  endtask

  task automatic backpressure_test();
    logic [6:0]  addrs [3];
    logic [31:0] exp [3];
    int          sent;
    int          got;
    addrs[0] = 7'(DATA0);
    addrs[1] = 7'(DATA0) + 7'd1;
    addrs[2] = 7'(PROGBUF0);
    exp[0]   = data_ref[0];
    exp[1]   = data_ref[1];
    exp[2]   = prog_ref[0];
    sent     = 0;
    got      = 0;
    dmi_resp_ready_i <= 1'b0;
    dmi_req_valid_i  <= 1'b1;
    dmi_req_i        <= '{addr: addrs[0], data: 32'h0, op: DTM_READ};
    while (sent < 2) begin
      @(posedge clk_i);
      assert (dmi_req_ready_o) else report_failure("request refused with room in the queue");
      sent++;
      dmi_req_i <= '{addr: addrs[sent], data: 32'h0, op: DTM_READ};
    end
    repeat (3) begin
      @(posedge clk_i);
      expect_eq("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h0);
      expect_eq("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'h1);
    end
    dmi_resp_ready_i <= 1'b1;
    while (got < 3) begin
      @(posedge clk_i);
      if (sent < 3 && dmi_req_ready_o) begin // third request goes in
        sent++;
        dmi_req_valid_i <= 1'b0;
        dmi_req_i       <= '{addr: 7'h0, data: 32'h0, op: DTM_NOP};
      end
      if (dmi_resp_valid_o) begin
        expect_eq("dmi_resp_o.data", dmi_resp_o.data, exp[got]);
        expect_eq("dmi_resp_o.resp", 32'(dmi_resp_o.resp), 32'(DTM_SUCCESS));
        got++;
      end
    end
  endtask

  initial begin
    rst_ni           = 1'b0;
    dmi_rst_ni       = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '{addr: 7'h0, data: 32'h0, op: DTM_NOP};
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CMDERR_NONE;
    cmdbusy_i        = 1'b0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni     <= 1'b1;
    dmi_rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_test();
    hart_test();
    data_test();
    command_test();
    autoexec_test();
    backpressure_test();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/dm_pkg.sv
source/dm_resp_fifo.sv
source/dm_hart_ctrl.sv
source/dm_abstract_regs.sv
source/dm_csr_ctrl.sv
source/dm_csrs_top.sv
sim/tb_dm_csrs.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the debug module register testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_dm_csrs -o sim_tb_dm_csrs
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_dm_csrs 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1
